//--- include/backplane_settings.svh
// Build settings for the drive-bay control logic
// Slot count, blink tick length, host register map, reset defaults and
// header bytes. Included by every RTL file that needs one of them.

`ifndef BACKPLANE_SETTINGS_SVH
`define BACKPLANE_SETTINGS_SVH

// Drive bays, two status bytes hold up to 16
`define NUM_SLOTS       15

// Clocks per quarter-blink tick, small for simulation
`define TICK_CYCLES     4

// Host register map
`define ADDR_INSERT     8'h00
`define ADDR_P5V        8'h02
`define ADDR_P12V       8'h04
`define ADDR_PWR        8'h10
`define ADDR_HEALTH     8'h20
`define ADDR_FAULT      8'h30
`define ADDR_ALERT      8'h90
`define ADDR_SOFTRST    8'hA0
`define ADDR_HEADER     8'hF0

// Power bits are active low, so zero means powered
`define PWR_DFT         8'h00

// Both nibbles in mode on
`define LED_DFT         8'h11

// Header bytes
`define CPLD_MAJ_VER    8'h01
`define CPLD_MIN_VER    8'h03
`define CHECKSUM        8'h5A

`endif

//--- verilog/hostBusPkg.sv
// Types of the parallel host register port
// One write or read strobe per cycle, read data returns with a valid pulse

package hostBusPkg;

    typedef struct packed {
        logic       wrEn;
        logic       rdEn;
        logic [7:0] addr;
        logic [7:0] wrData;
    } hostReqT;

    typedef struct packed {
        logic       rdValid;
        logic [7:0] rdData;
    } hostRspT;

endpackage

//--- verilog/slotPkg.sv
// Types for one drive bay: board status, host control, pin outputs,
// LED modes, blink phases and alert causes

package slotPkg;

    typedef struct packed {
        logic insertN;
        logic p5vGood;
        logic p12vGood;
    } slotStatusT;

    // Codes not listed here light nothing
    typedef enum logic [3:0] {
        ledOff = 4'd0,
        ledOn  = 4'd1,
        led1Hz = 4'd2,
        led2Hz = 4'd3,
        led4Hz = 4'd4
    } ledModeT;

    typedef struct packed {
        logic    pwrOffN;
        ledModeT healthMode;
        ledModeT faultMode;
    } slotCtrlT;

    typedef struct packed {
        logic pwrEnN;
        logic healthLed;
        logic faultLed;
    } slotOutT;

    typedef struct packed {
        logic hz4;
        logic hz2;
        logic hz1;
    } blinkPhaseT;

    typedef struct packed {
        logic insertChg;
        logic p5vChg;
        logic p12vChg;
    } alertCauseT;

endpackage

//--- verilog/blinkTimebase.sv
// Shared blink time base for all slot LEDs and the heartbeat
// A tick every TICK_CYCLES clocks steps a 3-bit phase counter

`timescale 1ns/1ps
`include "backplane_settings.svh"

module blinkTimebase (
    input  logic                sysClk,
    input  logic                ctrlRstN,
    output slotPkg::blinkPhaseT phase
);
    localparam int tickW = $clog2(`TICK_CYCLES + 1);

    logic [tickW-1:0] tickCnt;
    logic [2:0]       phaseCnt;
    logic             tickEnd;

    assign tickEnd = tickCnt == tickW'(`TICK_CYCLES - 1);

    always_ff @(posedge sysClk) begin
        if (!ctrlRstN) begin
            tickCnt  <= '0;
            phaseCnt <= '0;
        end else begin
            tickCnt <= tickEnd ? '0 : tickCnt + 1'b1;
            if (tickEnd) begin
                phaseCnt <= phaseCnt + 3'd1;
            end
        end
    end

    // Bit 0 flips every tick, bit 2 every four
    assign phase = '{hz4: phaseCnt[0], hz2: phaseCnt[1], hz1: phaseCnt[2]};

    // Tick counter wraps before it reaches TICK_CYCLES
    assert property (@(posedge sysClk) disable iff (!ctrlRstN)
        tickCnt < tickW'(`TICK_CYCLES));

endmodule

//--- verilog/ctrlRegBank.sv
// Host writable register bank of any packed payload
// Byte addressed from baseAddr, reads back the addressed byte

`timescale 1ns/1ps

module ctrlRegBank #(
    parameter type        T        = logic [15:0],
    parameter T           rstVal   = '0,
    parameter logic [7:0] baseAddr = 8'h00
) (
    input  logic                sysClk,
    input  logic                ctrlRstN,
    input  hostBusPkg::hostReqT req,
    output T                    data,
    output logic [7:0]          rdData,
    output logic                hit
);
    localparam int nBytes = $bits(T) / 8;
    localparam int idxW   = (nBytes > 1) ? $clog2(nBytes) : 1;

    logic [nBytes-1:0][7:0] bytesQ;
    logic [7:0]             offset;
    logic [idxW-1:0]        idx;

    assign offset = req.addr - baseAddr;
    assign hit    = offset < 8'(nBytes);
    assign idx    = offset[idxW-1:0];
    assign rdData = bytesQ[idx];
    assign data   = T'(bytesQ);

    always_ff @(posedge sysClk) begin
        if (!ctrlRstN) begin
            bytesQ <= rstVal;
        end else if (req.wrEn && hit) begin
            bytesQ[idx] <= req.wrData;
        end
    end

    // Contents move only on an in-range write or a reset
    assert property (@(posedge sysClk) disable iff (!ctrlRstN)
        !$stable(bytesQ) |-> $past(!ctrlRstN || (req.wrEn && hit)));

endmodule

//--- verilog/slotCtrl.sv
// One drive bay: power enable gated by insert, health and fault LEDs
// driven from their mode registers and the shared blink phases

`timescale 1ns/1ps

module slotCtrl (
    input  logic                sysClk,
    input  logic                ctrlRstN,
    input  slotPkg::slotCtrlT   ctrl,
    input  slotPkg::slotStatusT status,
    input  slotPkg::blinkPhaseT phase,
    output slotPkg::slotOutT    out
);
    import slotPkg::*;

    function automatic logic ledLevel(ledModeT mode, blinkPhaseT ph);
        logic lvl;
        case (mode)
            ledOn:   lvl = 1'b1;
            led1Hz:  lvl = ph.hz1;
            led2Hz:  lvl = ph.hz2;
            led4Hz:  lvl = ph.hz4;
            default: lvl = 1'b0;
        endcase
        return lvl;
    endfunction

    // Empty bay is never powered
    always_ff @(posedge sysClk) begin
        if (!ctrlRstN) begin
            out <= '{pwrEnN: status.insertN, healthLed: 1'b1, faultLed: 1'b1};
        end else begin
            out <= '{pwrEnN:    ctrl.pwrOffN | status.insertN,
                     healthLed: ledLevel(ctrl.healthMode, phase),
                     faultLed:  ledLevel(ctrl.faultMode, phase)};
        end
    end

    assert property (@(posedge sysClk) disable iff (!ctrlRstN)
        status.insertN |=> out.pwrEnN);

endmodule

//--- verilog/statusCollector.sv
// Samples slot status, packs it into host read bytes and latches any
// change into sticky alert causes until the host reads the alert register

`timescale 1ns/1ps
`include "backplane_settings.svh"

module statusCollector (
    input  logic                                 sysClk,
    input  logic                                 rstN,
    input  slotPkg::slotStatusT [`NUM_SLOTS-1:0] status,
    input  logic                                 alertClr,
    output logic [5:0][7:0]                      statusBytes,
    output slotPkg::alertCauseT                  cause,
    output logic                                 alertN
);
    import slotPkg::*;

    slotStatusT [`NUM_SLOTS-1:0] sampleQ;
    logic [5:0][7:0]             prevBytes;
    logic [5:0][7:0]             diff;
    logic [15:0]                 insertV;
    logic [15:0]                 p5vV;
    logic [15:0]                 p12vV;
    alertCauseT                  chg;

    // Unused top bit of each pair reads 0
    always_comb begin
        insertV = '0;
        p5vV    = '0;
        p12vV   = '0;
        for (int i = 0; i < `NUM_SLOTS; i++) begin
            insertV[i] = sampleQ[i].insertN;
            p5vV[i]    = sampleQ[i].p5vGood;
            p12vV[i]   = sampleQ[i].p12vGood;
        end
    end

    assign statusBytes = {p12vV, p5vV, insertV};
    assign diff        = statusBytes ^ prevBytes;
    assign chg         = '{insertChg: |diff[1:0], p5vChg: |diff[3:2], p12vChg: |diff[5:4]};

    always_ff @(posedge sysClk) begin
        sampleQ   <= status;
        prevBytes <= statusBytes;
    end

    // Clear wins over a change in the same cycle
    always_ff @(posedge sysClk) begin
        if (!rstN) begin
            cause  <= '0;
            alertN <= 1'b1;
        end else begin
            cause  <= alertClr ? '0 : cause | chg;
            alertN <= ~|cause;
        end
    end

endmodule

//--- verilog/hostRegs.sv
// Host register front end
// Decodes the parallel port, holds the power and LED banks, makes the
// soft reset and returns read data two edges after the read strobe

`timescale 1ns/1ps
`include "backplane_settings.svh"

module hostRegs (
    input  logic                               sysClk,
    input  logic                               rstN,
    input  hostBusPkg::hostReqT                req,
    output hostBusPkg::hostRspT                rsp,
    output slotPkg::slotCtrlT [`NUM_SLOTS-1:0] slotCtrl,
    output logic                               ctrlRstN,
    input  logic [5:0][7:0]                    statusBytes,
    input  slotPkg::alertCauseT                cause,
    output logic                               alertClr
);
    import slotPkg::*;

    typedef logic [15:0]      pwrBankT;
    typedef logic [15:0][3:0] ledBankT;

    logic       softRst;
    pwrBankT    pwrBits;
    ledBankT    healthNib;
    ledBankT    faultNib;
    logic [7:0] pwrRd;
    logic [7:0] healthRd;
    logic [7:0] faultRd;
    logic       pwrHit;
    logic       healthHit;
    logic       faultHit;
    logic [7:0] rdMux;
    logic [7:0] rdDataQ;
    logic [7:0] rspDataQ;
    logic       rdPend;
    logic       rdValidQ;

    // Power and LED registers fall back to defaults on soft reset too
    assign ctrlRstN = rstN && !softRst;

    always_ff @(posedge sysClk) begin
        if (!rstN) begin
            softRst  <= 1'b0;
            alertClr <= 1'b0;
            rdPend   <= 1'b0;
            rdValidQ <= 1'b0;
        end else begin
            softRst  <= req.wrEn && req.addr == `ADDR_SOFTRST && req.wrData[0];
            alertClr <= req.rdEn && req.addr == `ADDR_ALERT;
            rdPend   <= req.rdEn;
            rdValidQ <= rdPend;
        end
    end

    ctrlRegBank #(.T(pwrBankT), .rstVal({2{`PWR_DFT}}), .baseAddr(`ADDR_PWR)) pwrBank_i (
        .sysClk   (sysClk),
        .ctrlRstN (ctrlRstN),
        .req      (req),
        .data     (pwrBits),
        .rdData   (pwrRd),
        .hit      (pwrHit)
    );

    ctrlRegBank #(.T(ledBankT), .rstVal({8{`LED_DFT}}), .baseAddr(`ADDR_HEALTH)) healthBank_i (
        .sysClk   (sysClk),
        .ctrlRstN (ctrlRstN),
        .req      (req),
        .data     (healthNib),
        .rdData   (healthRd),
        .hit      (healthHit)
    );

    ctrlRegBank #(.T(ledBankT), .rstVal({8{`LED_DFT}}), .baseAddr(`ADDR_FAULT)) faultBank_i (
        .sysClk   (sysClk),
        .ctrlRstN (ctrlRstN),
        .req      (req),
        .data     (faultNib),
        .rdData   (faultRd),
        .hit      (faultHit)
    );

    // Slot n sits in bit n, lower slot in the low nibble
    always_comb begin
        for (int i = 0; i < `NUM_SLOTS; i++) begin
            slotCtrl[i].pwrOffN    = pwrBits[i];
            slotCtrl[i].healthMode = ledModeT'(healthNib[i]);
            slotCtrl[i].faultMode  = ledModeT'(faultNib[i]);
        end
    end

    //**************************************************************************
    // Read path
    //**************************************************************************
    always_comb begin
        rdMux = pwrHit ? pwrRd : healthHit ? healthRd : faultHit ? faultRd : 8'h00;
        case (req.addr)
            `ADDR_INSERT:          rdMux = statusBytes[0];
            `ADDR_INSERT + 8'd1:   rdMux = statusBytes[1];
            `ADDR_P5V:             rdMux = statusBytes[2];
            `ADDR_P5V + 8'd1:      rdMux = statusBytes[3];
            `ADDR_P12V:            rdMux = statusBytes[4];
            `ADDR_P12V + 8'd1:     rdMux = statusBytes[5];
            `ADDR_ALERT:           rdMux = {5'b0, cause};
            `ADDR_HEADER:          rdMux = `CPLD_MAJ_VER;
            `ADDR_HEADER + 8'd1:   rdMux = `CPLD_MIN_VER;
            `ADDR_HEADER + 8'd2:   rdMux = `CHECKSUM;
            default: ;
        endcase
    end

    always_ff @(posedge sysClk) begin
        rdDataQ  <= rdMux;
        rspDataQ <= rdDataQ;
    end

    assign rsp = '{rdValid: rdValidQ, rdData: rspDataQ};

endmodule

//--- verilog/backplaneTop.sv
// Drive-bay backplane controller top level
// Host register port in, per-slot power and LED pins, heartbeat and alert out

`timescale 1ns/1ps
`include "backplane_settings.svh"

module backplaneTop (
    input  logic                                 sysClk,
    input  logic                                 rstN,
    input  hostBusPkg::hostReqT                  req,
    output hostBusPkg::hostRspT                  rsp,
    input  slotPkg::slotStatusT [`NUM_SLOTS-1:0] slotStatus,
    output slotPkg::slotOutT [`NUM_SLOTS-1:0]    slotOut,
    output logic                                 heart,
    output logic                                 alertN
);
    import slotPkg::*;

    slotCtrlT [`NUM_SLOTS-1:0] ctrlArr;
    blinkPhaseT                phase;
    alertCauseT                cause;
    logic [5:0][7:0]           statusBytes;
    logic                      ctrlRstN;
    logic                      alertClr;

    hostRegs hostRegs_i (
        .sysClk      (sysClk),
        .rstN        (rstN),
        .req         (req),
        .rsp         (rsp),
        .slotCtrl    (ctrlArr),
        .ctrlRstN    (ctrlRstN),
        .statusBytes (statusBytes),
        .cause       (cause),
        .alertClr    (alertClr)
    );

    blinkTimebase blinkTimebase_i (
        .sysClk   (sysClk),
        .ctrlRstN (ctrlRstN),
        .phase    (phase)
    );

    for (genvar i = 0; i < `NUM_SLOTS; i++) begin : genSlot
        slotCtrl slotCtrl_i (
            .sysClk   (sysClk),
            .ctrlRstN (ctrlRstN),
            .ctrl     (ctrlArr[i]),
            .status   (slotStatus[i]),
            .phase    (phase),
            .out      (slotOut[i])
        );
    end

    statusCollector statusCollector_i (
        .sysClk      (sysClk),
        .rstN        (rstN),
        .status      (slotStatus),
        .alertClr    (alertClr),
        .statusBytes (statusBytes),
        .cause       (cause),
        .alertN      (alertN)
    );

    // Heartbeat follows the 1 Hz phase
    assign heart = phase.hz1;

endmodule

//--- sim/backplaneTb.sv
// Self-checking testbench for the drive-bay backplane controller
// Drives the host register port and slot status from a step table and
// checks read data, slot pins, blink rates and the alert output.
// Built with the file list, top module backplaneTb.

`timescale 1ns/1ps
`include "backplane_settings.svh"

module backplaneTb;
    import hostBusPkg::*;
    import slotPkg::*;

    typedef slotStatusT [`NUM_SLOTS-1:0] statusArrT;
    typedef slotOutT [`NUM_SLOTS-1:0]    outArrT;
    typedef enum logic {opWr, opRd} opT;

    typedef struct packed {
        opT         op;
        logic [7:0] addr;
        logic [7:0] data;
        logic [7:0] expVal;
    } stepT;

    // About 100 host accesses of up to 6 cycles, plus blink window and settles
    localparam int hostOps    = 100;
    localparam int opCycles   = 6;
    localparam int waitCycles = 200;
    localparam int cycleLimit = 8 + hostOps * opCycles + waitCycles;

    logic        sysClk;
    logic        rstN;
    hostReqT     req;
    hostRspT     rsp;
    statusArrT   slotStatus;
    outArrT      slotOut;
    logic        heart;
    logic        alertN;

    stepT        steps[$];
    statusArrT   curStatus;
    logic [15:0] pwrModel;
    int          cycles = 0;

    backplaneTop backplaneTop_i (
        .sysClk     (sysClk),
        .rstN       (rstN),
        .req        (req),
        .rsp        (rsp),
        .slotStatus (slotStatus),
        .slotOut    (slotOut),
        .heart      (heart),
        .alertN     (alertN)
    );

    always #50 sysClk = ~sysClk;

    always @(posedge sysClk) begin
        cycles <= cycles + 1;
        if (cycles >= cycleLimit) begin
            stopRun("Timeout: the run went past its cycle limit");
        end
    end

    //**************************************************************************
    // Checks
    //**************************************************************************
    task automatic stopRun(input string line);
        $display("%s", line);
        $display("Verification failed");
        $fatal(1, "Run stopped at the first error");
    endtask

    task automatic checkByte(input logic [7:0] got, input logic [7:0] expVal,
                             input string what);
        if (got !== expVal) begin
            stopRun($sformatf("Fail at %0t ns: %s is 0x%02h, expected 0x%02h",
                              $time, what, got, expVal));
        end
    endtask

    task automatic checkSlotOut(input int slot, input slotOutT got, input slotOutT expVal);
        if (got !== expVal) begin
            stopRun($sformatf("Fail at %0t ns: slot %0d pwrEnN/health/fault %b, expected %b",
                              $time, slot, got, expVal));
        end
    endtask

    task automatic checkAlert(input logic got, input logic expVal, input string what);
        if (got !== expVal) begin
            stopRun($sformatf("Fail at %0t ns: %s is %b, expected %b",
                              $time, what, got, expVal));
        end
    endtask

    // Expected pins with an empty bay never powered
    function automatic slotOutT expOut(input int slot, input logic health, input logic fault);
        return '{pwrEnN: pwrModel[slot] | curStatus[slot].insertN,
                 healthLed: health, faultLed: fault};
    endfunction

    task automatic checkPins();
        for (int i = 0; i < `NUM_SLOTS; i++) begin
            checkSlotOut(i, slotOut[i], expOut(i, 1'b1, 1'b1));
        end
    endtask

    //**************************************************************************
    // Host port and status drive
    //**************************************************************************
    task automatic writeReg(input logic [7:0] addr, input logic [7:0] data);
        @(posedge sysClk);
        req <= '{wrEn: 1'b1, rdEn: 1'b0, addr: addr, wrData: data};
        @(posedge sysClk);
        req <= '0;
    endtask

    task automatic readReg(input logic [7:0] addr, output logic [7:0] data);
        @(posedge sysClk);
        req <= '{wrEn: 1'b0, rdEn: 1'b1, addr: addr, wrData: 8'h00};
        @(posedge sysClk);
        req <= '0;
        @(negedge sysClk);
        while (!rsp.rdValid) begin
            @(negedge sysClk);
        end
        data = rsp.rdData;
    endtask

    task automatic settle();
        repeat (2) @(negedge sysClk);
    endtask

    function automatic statusArrT randomStatus();
        statusArrT s;
        for (int i = 0; i < `NUM_SLOTS; i++) begin
            s[i] = 3'($urandom_range(7, 0));
        end
        return s;
    endfunction

    task automatic driveStatus(input statusArrT s);
        @(posedge sysClk);
        slotStatus <= s;
        curStatus = s;
    endtask

    // Field 0 insert, 1 5 V good, 2 12 V good
    function automatic logic [15:0] packBits(input statusArrT s, input int field);
        logic [15:0] v;
        v = '0;
        for (int i = 0; i < `NUM_SLOTS; i++) begin
            case (field)
                0:       v[i] = s[i].insertN;
                1:       v[i] = s[i].p5vGood;
                default: v[i] = s[i].p12vGood;
            endcase
        end
        return v;
    endfunction

    //**************************************************************************
    // Step table
    //**************************************************************************
    task automatic addStep(input opT op, input logic [7:0] addr, input logic [7:0] data,
                           input logic [7:0] expVal);
        steps.push_back('{op: op, addr: addr, data: data, expVal: expVal});
    endtask

    task automatic addDefaultReads();
        addStep(opRd, `ADDR_PWR, 8'h00, `PWR_DFT);
        addStep(opRd, `ADDR_PWR + 8'd1, 8'h00, `PWR_DFT);
        for (int i = 0; i < 8; i++) begin
            addStep(opRd, `ADDR_HEALTH + 8'(i), 8'h00, `LED_DFT);
            addStep(opRd, `ADDR_FAULT + 8'(i), 8'h00, `LED_DFT);
        end
    endtask

    // Status pairs sit two bytes apart
    task automatic addStatusReads();
        logic [15:0] v;
        for (int f = 0; f < 3; f++) begin
            v = packBits(curStatus, f);
            addStep(opRd, `ADDR_INSERT + 8'(2 * f), 8'h00, v[7:0]);
            addStep(opRd, `ADDR_INSERT + 8'(2 * f + 1), 8'h00, v[15:8]);
        end
    endtask

    task automatic runTable(input string name);
        logic [7:0] rd;
        foreach (steps[i]) begin
            if (steps[i].op == opWr) begin
                writeReg(steps[i].addr, steps[i].data);
            end else begin
                readReg(steps[i].addr, rd);
                checkByte(rd, steps[i].expVal,
                          $sformatf("%s step %0d, addr 0x%02h", name, i, steps[i].addr));
            end
        end
        steps.delete();
    endtask

    //**************************************************************************
    // LED blinking and alert sequences
    //**************************************************************************
    // Slot LEDs are registered, so they trail heart by one cycle
    task automatic checkBlink();
        logic prevHeart;
        logic prev2Hz;
        logic prev4Hz;
        int   togHeart;
        int   tog2Hz;
        int   tog4Hz;
        togHeart  = 0;
        tog2Hz    = 0;
        tog4Hz    = 0;
        prevHeart = heart;
        prev2Hz   = slotOut[3].healthLed;
        prev4Hz   = slotOut[4].healthLed;
        // One heart period is 8 ticks
        for (int c = 0; c < 8 * `TICK_CYCLES; c++) begin
            @(negedge sysClk);
            checkSlotOut(0, slotOut[0], expOut(0, 1'b0, 1'b0));
            checkSlotOut(1, slotOut[1], expOut(1, 1'b1, 1'b0));
            checkSlotOut(2, slotOut[2], expOut(2, prevHeart, 1'b1));
            checkSlotOut(5, slotOut[5], expOut(5, 1'b0, 1'b1));
            if (heart != prevHeart) begin
                togHeart++;
            end
            if (slotOut[3].healthLed != prev2Hz) begin
                tog2Hz++;
            end
            if (slotOut[4].healthLed != prev4Hz) begin
                tog4Hz++;
            end
            prevHeart = heart;
            prev2Hz   = slotOut[3].healthLed;
            prev4Hz   = slotOut[4].healthLed;
        end
        checkByte(8'(togHeart), 8'd2, "heart toggles per heart period");
        checkByte(8'(tog2Hz), 8'd4, "2 Hz toggles per heart period");
        checkByte(8'(tog4Hz), 8'd8, "4 Hz toggles per heart period");
    endtask

    task automatic raiseChange(input int field);
        statusArrT s;
        int        slot;
        s    = curStatus;
        slot = $urandom_range(`NUM_SLOTS - 1, 0);
        case (field)
            0:       s[slot].insertN  = ~s[slot].insertN;
            1:       s[slot].p5vGood  = ~s[slot].p5vGood;
            default: s[slot].p12vGood = ~s[slot].p12vGood;
        endcase
        driveStatus(s);
        for (int c = 0; c < 3 && alertN; c++) begin
            @(posedge sysClk);
            @(negedge sysClk);
        end
        checkAlert(alertN, 1'b0, "alertN after a status change");
    endtask

    task automatic checkAlertCause(input int field, input logic [7:0] expCause);
        logic [7:0] rd;
        raiseChange(field);
        readReg(`ADDR_ALERT, rd);
        checkByte(rd, expCause, "alert cause");
        @(negedge sysClk);
        checkAlert(alertN, 1'b1, "alertN after the alert read");
        readReg(`ADDR_ALERT, rd);
        checkByte(rd, 8'h00, "second alert read");
    endtask

    initial begin
        statusArrT  s;
        logic [7:0] rd;
        void'($urandom(32'h8857_38c5));
        sysClk     = 1'b0;
        rstN       = 1'b0;
        req        = '0;
        pwrModel   = '0;
        curStatus  = randomStatus();
        slotStatus = curStatus;
        repeat (8) @(posedge sysClk);
        rstN <= 1'b1;

        // Header and defaults after reset
        addStep(opRd, `ADDR_HEADER, 8'h00, `CPLD_MAJ_VER);
        addStep(opRd, `ADDR_HEADER + 8'd1, 8'h00, `CPLD_MIN_VER);
        addStep(opRd, `ADDR_HEADER + 8'd2, 8'h00, `CHECKSUM);
        addDefaultReads();
        runTable("reset");
        checkAlert(alertN, 1'b1, "alertN after reset");
        checkPins();

        for (int n = 0; n < 4; n++) begin
            driveStatus(randomStatus());
            addStatusReads();
            runTable("status");
        end

        // Power bits, then every bay filled and one pulled
        pwrModel = 16'($urandom);
        addStep(opWr, `ADDR_PWR, pwrModel[7:0], 8'h00);
        addStep(opWr, `ADDR_PWR + 8'd1, pwrModel[15:8], 8'h00);
        runTable("power");
        settle();
        checkPins();
        addStep(opRd, `ADDR_PWR + 8'd1, 8'h00, pwrModel[15:8]);
        runTable("power read");
        pwrModel = '0;
        addStep(opWr, `ADDR_PWR, 8'h00, 8'h00);
        addStep(opWr, `ADDR_PWR + 8'd1, 8'h00, 8'h00);
        runTable("power clear");
        s = curStatus;
        for (int i = 0; i < `NUM_SLOTS; i++) begin
            s[i].insertN = 1'b0;
        end
        driveStatus(s);
        settle();
        checkPins();
        s[6].insertN = 1'b1;
        driveStatus(s);
        settle();
        checkPins();

        // Slots 0 to 5 get off, on, 1 Hz, 2 Hz, 4 Hz and an undefined code
        addStep(opWr, `ADDR_HEALTH, 8'h10, 8'h00);
        addStep(opWr, `ADDR_HEALTH + 8'd1, 8'h32, 8'h00);
        addStep(opWr, `ADDR_HEALTH + 8'd2, 8'h74, 8'h00);
        addStep(opWr, `ADDR_FAULT, 8'hF9, 8'h00);
        addStep(opRd, `ADDR_HEALTH + 8'd2, 8'h00, 8'h74);
        runTable("led");
        settle();
        checkBlink();

        readReg(`ADDR_ALERT, rd);
        @(negedge sysClk);
        checkAlert(alertN, 1'b1, "alertN after clearing old changes");
        checkAlertCause(0, 8'h04);
        checkAlertCause(1, 8'h02);
        checkAlertCause(2, 8'h01);

        // Soft reset keeps status and the pending alert
        raiseChange(1);
        addStep(opWr, `ADDR_PWR, 8'hC3, 8'h00);
        addStep(opWr, `ADDR_FAULT + 8'd5, 8'h24, 8'h00);
        addStep(opWr, `ADDR_SOFTRST, 8'h01, 8'h00);
        addDefaultReads();
        addStatusReads();
        runTable("soft reset");
        checkAlert(alertN, 1'b0, "alertN after soft reset");
        readReg(`ADDR_ALERT, rd);
        checkByte(rd, 8'h02, "alert cause after soft reset");
        pwrModel = '0;
        checkPins();

        $display("Verification passed");
        $finish;
    end

endmodule

//--- sources.f
+incdir+include
verilog/hostBusPkg.sv
verilog/slotPkg.sv
verilog/blinkTimebase.sv
verilog/ctrlRegBank.sv
verilog/slotCtrl.sv
verilog/statusCollector.sv
verilog/hostRegs.sv
verilog/backplaneTop.sv
sim/backplaneTb.sv

//--- Makefile
TOOL    = verilator
FLAGS   = --binary --timing --assert -j 0
TOP     = backplaneTb
FLIST   = sources.f
OBJDIR  = obj_dir
LOG     = sim.log
PASSMSG = Verification passed

.PHONY: all compile run clean

all: run

compile:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJDIR)

# The log decides the result, the simulator status alone does not
run: compile
	-./$(OBJDIR)/V$(TOP) > $(LOG) 2>&1
	cat $(LOG)
	grep -q "$(PASSMSG)" $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)
